/* rx_dsp_macros.svh */
`ifndef RX_DSP_MACROS_SVH
`define RX_DSP_MACROS_SVH

// equalizer depth, tap 0 is the newest code
`define RX_FFE_TAPS 4

// signed adc code width
`define RX_CODE_W 8

// signed tap weight width
`define RX_WEIGHT_W 8

// output right shift amount
`define RX_SHIFT_W 4

// saturated equalizer output
`define RX_RESULT_W 10

// four 8x8 products need two guard bits
`define RX_ACC_W 18

// phase interpolator code
`define RX_PI_W 8

// unsigned phase integrator, pi code is its top byte
`define RX_INT_W 16

// 64 >>> 6 gives unity gain on tap 0
`define RX_W0_RESET 64
`define RX_SHIFT_RESET 6

`endif

/* rx_dsp_pkg.sv */
`default_nettype none

`include "rx_dsp_macros.svh"

package rx_dsp_pkg;

    // configuration opcodes
    typedef enum logic [1:0] {
        CFG_NOP      = 2'd0,
        CFG_WEIGHT   = 2'd1,
        CFG_SHIFT    = 2'd2,
        CFG_PI_CLEAR = 2'd3
    } cfg_op_e;

    // one configuration write, 12 bits
    typedef struct packed {
        cfg_op_e    op;
        // tap index, only used by weight writes
        logic [1:0] addr;
        // weight value or shift in the low bits
        logic [7:0] data;
    } cfg_cmd_t;

    // signed tap weight
    typedef logic signed [`RX_WEIGHT_W-1:0] weight_t;

    // live equalizer setting, 36 bits
    typedef struct packed {
        weight_t [`RX_FFE_TAPS-1:0]  weight;
        logic    [`RX_SHIFT_W-1:0]   shift;
    } ffe_cfg_t;

    // equalized sample with its strobe, 11 bits
    typedef struct packed {
        logic                           valid;
        logic signed [`RX_RESULT_W-1:0] value;
    } eq_sample_t;

endpackage

`default_nettype wire

/* rx_cfg_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_macros.svh"

module rx_cfg_decode (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire rx_dsp_pkg::cfg_cmd_t cfg_i,
    input  wire logic                 cfg_valid_i,
    output rx_dsp_pkg::ffe_cfg_t      ffe_cfg_o,
    output logic                      pi_clear_o
);

    // the one copy of the equalizer setting
    rx_dsp_pkg::ffe_cfg_t cfg_d;
    rx_dsp_pkg::ffe_cfg_t cfg_q;
    logic                 pi_clear_d;

    // next-state decode of a single write
    always_comb begin
        cfg_d      = cfg_q;
        pi_clear_d = 1'b0;
        if (cfg_valid_i) begin
            unique case (cfg_i.op)
                rx_dsp_pkg::CFG_WEIGHT: begin
                    // addressed tap only
                    cfg_d.weight[cfg_i.addr] = $signed(cfg_i.data);
                end
                rx_dsp_pkg::CFG_SHIFT: begin
                    // low nibble holds the shift
                    cfg_d.shift = cfg_i.data[`RX_SHIFT_W-1:0];
                end
                rx_dsp_pkg::CFG_PI_CLEAR: begin
                    pi_clear_d = 1'b1;
                end
                rx_dsp_pkg::CFG_NOP: begin
                    // nothing changes
                    cfg_d = cfg_q;
                end
                default: begin
                    cfg_d = cfg_q;
                end
            endcase
        end
    end

    // weights and shift, reset to pass-through
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < `RX_FFE_TAPS; k++) begin
                cfg_q.weight[k] <= '0;
            end
            // tap 0 at unity after the shift
            cfg_q.weight[0] <= rx_dsp_pkg::weight_t'(`RX_W0_RESET);
            cfg_q.shift     <= `RX_SHIFT_W'(`RX_SHIFT_RESET);
        end else begin
            cfg_q <= cfg_d;
        end
    end

    // single-cycle clear pulse for the phase detector
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pi_clear_o <= 1'b0;
        end else begin
            pi_clear_o <= pi_clear_d;
        end
    end

    // new setting is seen from the cycle after the write
    assign ffe_cfg_o = cfg_q;

endmodule

`default_nettype wire

/* rx_ffe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_macros.svh"

module rx_ffe (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic signed [`RX_CODE_W-1:0] adc_code_i,
    input  wire logic                         adc_valid_i,
    input  wire rx_dsp_pkg::ffe_cfg_t         ffe_cfg_i,
    output rx_dsp_pkg::eq_sample_t            eq_o
);

    localparam int TAPS = `RX_FFE_TAPS;

    // output clamp limits, at accumulator width
    localparam logic signed [`RX_ACC_W-1:0] SAT_MAX = (2 ** (`RX_RESULT_W - 1)) - 1;
    localparam logic signed [`RX_ACC_W-1:0] SAT_MIN = -(2 ** (`RX_RESULT_W - 1));

    // older codes, hist_q[0] is the previous sample
    logic signed [`RX_CODE_W-1:0]   hist_q [TAPS-1];
    // tap view with the incoming code in front
    logic signed [`RX_CODE_W-1:0]   tap_code [TAPS];
    logic signed [`RX_ACC_W-1:0]    prod [TAPS];
    logic signed [`RX_ACC_W-1:0]    acc_d;

    // stage 1
    logic                           s1_valid_q;
    logic signed [`RX_ACC_W-1:0]    acc_q;
    logic [`RX_SHIFT_W-1:0]         shift_q;

    // stage 2
    logic signed [`RX_ACC_W-1:0]    shifted;
    logic signed [`RX_RESULT_W-1:0] sat_d;
    logic                           eq_valid_q;
    logic signed [`RX_RESULT_W-1:0] eq_value_q;

    // current code joins the history combinationally
    always_comb begin
        tap_code[0] = adc_code_i;
        for (int k = 1; k < TAPS; k++) begin
            tap_code[k] = hist_q[k-1];
        end
    end

    // signed products, summed at full width
    always_comb begin
        acc_d = '0;
        for (int k = 0; k < TAPS; k++) begin
            prod[k] = $signed(ffe_cfg_i.weight[k]) * tap_code[k];
            acc_d   = acc_d + prod[k];
        end
    end

    // code history, shifts only on a valid sample
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < TAPS - 1; k++) begin
                hist_q[k] <= '0;
            end
        end else if (adc_valid_i) begin
            hist_q[0] <= adc_code_i;
            for (int k = 1; k < TAPS - 1; k++) begin
                hist_q[k] <= hist_q[k-1];
            end
        end
    end

    // valid pipe through both stages
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            eq_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= adc_valid_i;
            eq_valid_q <= s1_valid_q;
        end
    end

    // shift travels with its sum so a write never splits a sample
    always_ff @(posedge clk_i) begin
        if (adc_valid_i) begin
            acc_q   <= acc_d;
            shift_q <= ffe_cfg_i.shift;
        end
    end

    // arithmetic shift then clamp to the output range
    always_comb begin
        shifted = acc_q >>> shift_q;
        if (shifted > SAT_MAX) begin
            sat_d = SAT_MAX[`RX_RESULT_W-1:0];
        end else if (shifted < SAT_MIN) begin
            sat_d = SAT_MIN[`RX_RESULT_W-1:0];
        end else begin
            sat_d = shifted[`RX_RESULT_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            eq_value_q <= sat_d;
        end
    end

    assign eq_o.valid = eq_valid_q;
    assign eq_o.value = eq_value_q;

endmodule

`default_nettype wire

/* rx_slicer_pd.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_macros.svh"

module rx_slicer_pd (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire rx_dsp_pkg::eq_sample_t eq_i,
    input  wire logic                   pi_clear_i,
    output logic                        data_o,
    output logic                        data_valid_o,
    output logic [`RX_PI_W-1:0]         pi_code_o
);

    // error spans two values of either sign
    localparam int ERR_W = `RX_RESULT_W + 2;
    // sum headroom for both saturation checks
    localparam int SUM_W = `RX_INT_W + 2;

    // mid-scale, top byte reads 128
    localparam logic [`RX_INT_W-1:0] INT_RESET = 1 << (`RX_INT_W - 1);
    localparam logic signed [SUM_W-1:0] INT_MAX = (2 ** `RX_INT_W) - 1;

    // previous value and decision pair
    logic signed [`RX_RESULT_W-1:0] prev_value_q;
    logic                           prev_dec_q;

    logic                           cur_dec;
    logic signed [ERR_W-1:0]        cur_ext;
    logic signed [ERR_W-1:0]        prev_ext;
    logic signed [ERR_W-1:0]        cur_term;
    logic signed [ERR_W-1:0]        prev_term;
    logic signed [ERR_W-1:0]        pd_err;

    logic signed [SUM_W-1:0]        int_sum;
    logic [`RX_INT_W-1:0]           int_d;
    logic [`RX_INT_W-1:0]           int_q;

    // sign slicer, zero counts as a 0
    assign cur_dec = (eq_i.value > 0);

    // mueller-muller: x[n]*d[n-1] - x[n-1]*d[n], with d as +1 or -1
    always_comb begin
        cur_ext   = ERR_W'(eq_i.value);
        prev_ext  = ERR_W'(prev_value_q);
        cur_term  = prev_dec_q ? cur_ext : -cur_ext;
        prev_term = cur_dec ? prev_ext : -prev_ext;
        pd_err    = cur_term - prev_term;
    end

    // integrate and clamp at both ends
    always_comb begin
        int_sum = $signed({2'b00, int_q}) + SUM_W'(pd_err);
        if (int_sum < 0) begin
            int_d = '0;
        end else if (int_sum > INT_MAX) begin
            int_d = '1;
        end else begin
            int_d = int_sum[`RX_INT_W-1:0];
        end
    end

    // clear wins over a sample in the same cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            int_q <= INT_RESET;
        end else if (pi_clear_i) begin
            int_q <= INT_RESET;
        end else if (eq_i.valid) begin
            int_q <= int_d;
        end
    end

    // previous-sample state restarts on clear as well
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_value_q <= '0;
            prev_dec_q   <= 1'b0;
        end else if (pi_clear_i) begin
            prev_value_q <= '0;
            prev_dec_q   <= 1'b0;
        end else if (eq_i.valid) begin
            prev_value_q <= eq_i.value;
            prev_dec_q   <= cur_dec;
        end
    end

    // recovered bit, one cycle after eq
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_o       <= 1'b0;
            data_valid_o <= 1'b0;
        end else begin
            data_valid_o <= eq_i.valid;
            if (eq_i.valid) begin
                data_o <= cur_dec;
            end
        end
    end

    // updates on the same edge as data_o
    assign pi_code_o = int_q[`RX_INT_W-1 -: `RX_PI_W];

endmodule

`default_nettype wire

/* rx_dsp_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_macros.svh"

module rx_dsp_top (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic signed [`RX_CODE_W-1:0] adc_code_i,
    input  wire logic                         adc_valid_i,
    input  wire rx_dsp_pkg::cfg_cmd_t         cfg_i,
    input  wire logic                         cfg_valid_i,
    output rx_dsp_pkg::eq_sample_t            eq_o,
    output logic                              data_o,
    output logic                              data_valid_o,
    output logic [`RX_PI_W-1:0]               pi_code_o
);

    // decode to ffe
    rx_dsp_pkg::ffe_cfg_t   ffe_cfg;
    // decode to phase detector
    logic                   pi_clear;
    // ffe to slicer and out
    rx_dsp_pkg::eq_sample_t eq;

    // configuration writes
    rx_cfg_decode i_cfg_decode (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg_i),
        .cfg_valid_i (cfg_valid_i),
        .ffe_cfg_o   (ffe_cfg),
        .pi_clear_o  (pi_clear)
    );

    // equalizer, two cycles
    rx_ffe i_ffe (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .adc_code_i  (adc_code_i),
        .adc_valid_i (adc_valid_i),
        .ffe_cfg_i   (ffe_cfg),
        .eq_o        (eq)
    );

    // decision and phase tracking, one more cycle
    rx_slicer_pd i_slicer_pd (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .eq_i         (eq),
        .pi_clear_i   (pi_clear),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .pi_code_o    (pi_code_o)
    );

    assign eq_o = eq;

endmodule

`default_nettype wire

/* tb_rx_dsp.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dsp_macros.svh"

module tb_rx_dsp;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_REC      = 128;
    // random gaps are 0 to 3 idle cycles
    localparam int MAX_GAP      = 3;

    logic                         clk_i;
    logic                         rst_n_i;
    logic signed [`RX_CODE_W-1:0] adc_code_i;
    logic                         adc_valid_i;
    rx_dsp_pkg::cfg_cmd_t         cfg_i;
    logic                         cfg_valid_i;
    rx_dsp_pkg::eq_sample_t       eq_o;
    logic                         data_o;
    logic                         data_valid_o;
    logic [`RX_PI_W-1:0]          pi_code_o;

    // records as read with a kind letter and up to four fields
    int rec_kind [MAX_REC];
    int rec_f [MAX_REC][4];
    int n_rec;

    // expectations waiting for their output strobe
    rx_dsp_pkg::eq_sample_t exp_eq_q [$];
    logic                   exp_bit_q [$];
    logic [`RX_PI_W-1:0]    exp_pi_q [$];

    integer seed;
    int     cycle_count;
    int     cycle_limit;
    bit     gap_mode;
    bit     checking;

    rx_dsp_top i_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .adc_code_i   (adc_code_i),
        .adc_valid_i  (adc_valid_i),
        .cfg_i        (cfg_i),
        .cfg_valid_i  (cfg_valid_i),
        .eq_o         (eq_o),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .pi_code_o    (pi_code_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_eq(input rx_dsp_pkg::eq_sample_t got,
                            input rx_dsp_pkg::eq_sample_t exp, input string what);
        if (got.valid !== exp.valid) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s valid %b, expected %b",
                                $time, what, got.valid, exp.valid));
        end else if (exp.valid && got.value !== exp.value) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s value %0d, expected %0d",
                                $time, what, $signed(got.value), $signed(exp.value)));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_pi(input logic [`RX_PI_W-1:0] got,
                            input logic [`RX_PI_W-1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic read_records();
        int    fd;
        int    got;
        int    ch;
        int    a;
        int    b;
        int    c;
        int    d;
        bit    ok;
        string line;
        fd = $fopen("rx_dsp_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file rx_dsp_input.txt");
        end
        n_rec = 0;
        got = $fscanf(fd, " %c", ch);
        while (got == 1) begin
            a = 0;
            b = 0;
            c = 0;
            d = 0;
            if (ch == "#") begin
                // rest of a comment line is dropped
                got = $fgets(line, fd);
            end else begin
                if (ch == "C") begin
                    ok = ($fscanf(fd, "%d %d %d", a, b, c) == 3);
                end else if (ch == "S") begin
                    ok = ($fscanf(fd, "%d %d %d %d", a, b, c, d) == 4);
                end else if (ch == "I") begin
                    ok = ($fscanf(fd, "%d", a) == 1);
                end else begin
                    ok = 1'b0;
                end
                if (!ok || n_rec == MAX_REC) begin
                    abort_run($sformatf("record %0d of rx_dsp_input.txt is malformed",
                                        n_rec + 1));
                end
                rec_kind[n_rec] = ch;
                rec_f[n_rec][0] = a;
                rec_f[n_rec][1] = b;
                rec_f[n_rec][2] = c;
                rec_f[n_rec][3] = d;
                n_rec++;
            end
            got = $fscanf(fd, " %c", ch);
        end
        $fclose(fd);
    endtask

    task automatic drive_record(input int idx);
        int                     gap;
        int                     val;
        rx_dsp_pkg::eq_sample_t exp_eq;
        if (rec_kind[idx] == "C") begin
            val = rec_f[idx][0];
            cfg_i.op = rx_dsp_pkg::cfg_op_e'(val[1:0]);
            val = rec_f[idx][1];
            cfg_i.addr = val[1:0];
            // negative weights arrive as two's complement
            val = rec_f[idx][2];
            cfg_i.data = val[7:0];
            cfg_valid_i = 1'b1;
            next_cycle();
            cfg_valid_i = 1'b0;
        end else if (rec_kind[idx] == "S") begin
            if (gap_mode) begin
                gap = $unsigned($random(seed)) % (MAX_GAP + 1);
                repeat (gap) next_cycle();
            end
            val = rec_f[idx][1];
            exp_eq.valid = 1'b1;
            exp_eq.value = val[`RX_RESULT_W-1:0];
            exp_eq_q.push_back(exp_eq);
            val = rec_f[idx][2];
            exp_bit_q.push_back(val[0]);
            val = rec_f[idx][3];
            exp_pi_q.push_back(val[`RX_PI_W-1:0]);
            val = rec_f[idx][0];
            adc_code_i = val[`RX_CODE_W-1:0];
            adc_valid_i = 1'b1;
            next_cycle();
            adc_valid_i = 1'b0;
        end else begin
            repeat (rec_f[idx][0]) next_cycle();
        end
    endtask

    task automatic apply_reset();
        rx_dsp_pkg::eq_sample_t idle_eq;
        checking = 1'b0;
        rst_n_i  = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        rst_n_i = 1'b1;
        idle_eq.valid = 1'b0;
        idle_eq.value = '0;
        check_eq(eq_o, idle_eq, "eq after reset");
        check_bit(data_valid_o, 1'b0, "data valid after reset");
        check_bit(data_o, 1'b0, "data bit after reset");
        // integrator at mid-scale
        check_pi(pi_code_o, 8'd128, "phase code after reset");
        checking = 1'b1;
    endtask

    task automatic wait_drain();
        while (exp_eq_q.size() != 0 || exp_bit_q.size() != 0) begin
            next_cycle();
        end
        // a few more cycles to catch stray strobes
        repeat (4) next_cycle();
    endtask

    // registered outputs are settled by the falling edge
    always @(negedge clk_i) begin
        if (checking && eq_o.valid) begin
            if (exp_eq_q.size() == 0) begin
                abort_run("the equalizer gave a sample that no record asked for");
            end
            check_eq(eq_o, exp_eq_q.pop_front(), "equalized sample");
        end
        if (checking && data_valid_o) begin
            if (exp_bit_q.size() == 0) begin
                abort_run("the slicer gave a bit that no record asked for");
            end
            check_bit(data_o, exp_bit_q.pop_front(), "sliced bit");
            check_pi(pi_code_o, exp_pi_q.pop_front(), "phase code");
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("the run timed out after %0d cycles", cycle_count));
        end
    end

    initial begin
        rst_n_i     = 1'b0;
        adc_code_i  = '0;
        adc_valid_i = 1'b0;
        cfg_i       = '0;
        cfg_valid_i = 1'b0;
        seed        = 47723;
        cycle_count = 0;
        cycle_limit = 0;
        gap_mode    = 1'b0;
        checking    = 1'b0;
        read_records();
        // four cycles per record cover both passes and their idle gaps
        cycle_limit = 4 * n_rec + 200;
        // back to back first and then with random idle gaps
        for (int pass = 0; pass < 2; pass++) begin
            gap_mode = (pass == 1);
            apply_reset();
            for (int i = 0; i < n_rec; i++) begin
                drive_record(i);
            end
            wait_drain();
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rx_dsp_input.txt */
# C op addr data (op 0 nop, 1 weight, 2 shift, 3 pi clear) | I idle_cycles
# S adc_code eq_value data_bit pi_code, all decimal
S 100 100 1 127
S -50 -50 0 127
S 0 0 0 127
S 127 127 1 127
S -128 -128 0 127
C 1 0 32
C 1 1 16
C 1 2 -8
C 2 0 4
C 0 3 255
S 10 -172 0 127
S 127 328 1 126
S 127 376 1 126
C 2 0 0
S 127 511 1 127
S -128 -512 0 127
C 1 0 64
C 1 1 0
C 1 2 0
C 2 0 6
I 2
C 3 0 0
S 0 0 0 128
S -60 -60 0 128
S 10 10 1 128
S 120 120 1 128
S -60 -60 0 129
S 10 10 1 129
S 120 120 1 129
S -60 -60 0 129
S 10 10 1 130
S 120 120 1 130
S -60 -60 0 130
I 2
C 3 0 0
S 0 0 0 128
S 127 127 1 127
S 50 50 1 127
C 1 0 -64
S 50 -50 0 127
S -30 30 1 127

/* sources.f */
+incdir+.
rx_dsp_pkg.sv
rx_cfg_decode.sv
rx_ffe.sv
rx_slicer_pd.sv
rx_dsp_top.sv
tb_rx_dsp.sv

/* Bender.yml */
package:
  name: rx_dsp

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rx_dsp_pkg.sv
      - rx_cfg_decode.sv
      - rx_ffe.sv
      - rx_slicer_pd.sv
      - rx_dsp_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rx_dsp.sv
